// File: src/st_glue_pkg.sv
// shared widths and constants for the st system glue
// every glue block pulls these in with a wildcard import in its header
package st_glue_pkg;

  // st cpu word address, bits 23 down to 1
  localparam int ram_addr_w      = 23;
  // sdram word address, bits 22 down to 1
  localparam int ram_word_addr_w = 22;
  // lowest of the two address bits xored on coldboot
  localparam int scramble_lo     = 3;

  // sd card sector interface
  localparam int sd_lba_w        = 32;
  localparam int sd_img_size_w   = 32;
  localparam int sd_byte_w       = 8;
  localparam int sd_chan_w       = 2;  // two drives per requester

  // keyboard matrix as seen by the ikbd
  localparam int kbd_rows        = 15;
  localparam int kbd_cols        = 8;

  // merged joystick, fire plus four directions
  localparam int joy_w           = 5;

  // boot wait counter
  localparam int boot_cnt_w      = 32;
  // 2 s at 32 MHz
  localparam logic [boot_cnt_w-1:0] boot_timeout_default = 32'd64_000_000;

  // sd arbiter owner encoding
  localparam logic owner_fdc     = 1'b0;
  localparam logic owner_acsi    = 1'b1;

endpackage

// File: src/boot_gate.sv
`timescale 1ns/10ps
// holds the st in reset until the mcu has mounted a disk image or the
// boot wait has run out, then folds in the board ready flags and resets
module boot_gate import st_glue_pkg::*; #(
  parameter logic [boot_cnt_w-1:0] timeout_cycles = boot_timeout_default
) (
  input  logic                     clk_32,
  input  logic                     rst_n,
  input  logic [sd_img_size_w-1:0] sd_img_size,   // nonzero once an image is mounted
  input  logic                     pll_lock,
  input  logic                     ram_ready,
  input  logic                     flash_ready,
  input  logic                     reset_button,  // high while pressed
  input  logic                     sys_reset_req, // reset request from the mcu
  output logic                     sd_ready,
  output logic                     core_reset_n
);

  logic [boot_cnt_w-1:0] wait_cnt; // cycles since reset release
  logic                  img_seen;
  logic                  timed_out;

  assign img_seen  = (sd_img_size != '0);
  assign timed_out = (wait_cnt >= timeout_cycles); // counter sits at the limit

  // wait for the mcu to open a default image
  always_ff @(posedge clk_32) begin
    if (!rst_n) begin
      wait_cnt <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_seen)
        sd_ready <= 1'b1; // card initialized, image present

      if (!timed_out)
        wait_cnt <= wait_cnt + 1'b1;
      else
        sd_ready <= 1'b1; // give up and boot without image
    end
  end

  // st runs only when every source agrees
  assign core_reset_n = sd_ready
                      & ram_ready
                      & flash_ready
                      & pll_lock
                      & ~reset_button
                      & ~sys_reset_req;

  // boot decision is sticky until the next reset
  a_sd_ready_sticky: assert property (
    @(posedge clk_32) (rst_n && sd_ready) |=> sd_ready
  );

endmodule

// File: src/ram_scrambler.sv
`timescale 1ns/10ps
// invalidates ram contents on every coldboot by xoring two word address
// bits with a counter, and blocks accesses to the upper 8 MB
module ram_scrambler import st_glue_pkg::*; (
  input  logic                     clk_32,
  input  logic                     rst_n,
  input  logic                     coldboot,     // coldboot flag from the mcu
  input  logic [ram_addr_w:1]      ram_req_addr, // chipset word address
  input  logic                     ram_ras_n,
  output logic [ram_word_addr_w:1] ram_addr_s,   // to the sdram controller
  output logic                     ram_cs
);

  logic       coldboot_d; // last sampled flag
  logic [1:0] scramble;   // coldboot edges mod 4

  always_ff @(posedge clk_32) begin
    if (!rst_n) begin
      coldboot_d <= 1'b0;
      scramble   <= 2'd0;
    end else begin
      coldboot_d <= coldboot;
      if (coldboot && !coldboot_d)
        scramble <= scramble + 2'd1; // wraps after four boots
    end
  end

  // bit 23 dropped and the two bits from scramble_lo up get the counter
  always_comb begin
    ram_addr_s = ram_req_addr[ram_word_addr_w:1];
    ram_addr_s[scramble_lo+1:scramble_lo] =
      ram_req_addr[scramble_lo+1:scramble_lo] ^ scramble;
  end

  assign ram_cs = ~ram_ras_n & ~ram_req_addr[ram_addr_w]; // only lower 8 MB

  // each coldboot edge moves the scramble on by one
  a_scramble_step: assert property (
    @(posedge clk_32) disable iff (!rst_n)
      $rose(coldboot) |=> (scramble == $past(scramble) + 2'd1)
  );

endmodule

// File: src/sd_arbiter.sv
`timescale 1ns/10ps
// shares the single sd sector interface between floppy and acsi
// the last requester keeps ownership so its lba and write data stay selected
module sd_arbiter import st_glue_pkg::*; (
  input  logic                   clk_32,
  input  logic                   rst_n,
  // floppy controller side
  input  logic [sd_chan_w-1:0]   fdc_rd,
  input  logic [sd_chan_w-1:0]   fdc_wr,
  input  logic [sd_lba_w-1:0]    fdc_lba,
  input  logic [sd_byte_w-1:0]   fdc_wr_byte,
  // acsi hard disk side
  input  logic [sd_chan_w-1:0]   acsi_rd,
  input  logic [sd_chan_w-1:0]   acsi_wr,
  input  logic [sd_lba_w-1:0]    acsi_lba,
  input  logic [sd_byte_w-1:0]   acsi_wr_byte,
  // sd card side
  output logic [2*sd_chan_w-1:0] sd_rd_req, // acsi channels on top
  output logic [2*sd_chan_w-1:0] sd_wr_req,
  output logic [sd_lba_w-1:0]    sd_lba,
  output logic [sd_byte_w-1:0]   sd_wr_byte
);

  logic owner;     // owner_fdc or owner_acsi
  logic owner_nxt;
  logic fdc_req;
  logic acsi_req;
  logic sel_acsi;

  assign fdc_req  = |{fdc_rd, fdc_wr};
  assign acsi_req = |{acsi_rd, acsi_wr};

  // two state fsm, the latest requester wins
  always_comb begin
    owner_nxt = owner;
    case (owner)
      owner_fdc: begin
        if (acsi_req)
          owner_nxt = owner_acsi;
      end
      owner_acsi: begin
        if (fdc_req)
          owner_nxt = owner_fdc;
      end
      default: owner_nxt = owner_fdc;
    endcase
  end

  always_ff @(posedge clk_32) begin
    if (!rst_n)
      owner <= owner_fdc;
    else if (fdc_req || acsi_req)
      owner <= owner_nxt; // only moves on a request
  end

  // an acsi request takes the port at once, before the owner flop follows
  assign sel_acsi = acsi_req || (owner == owner_acsi);

  assign sd_rd_req  = {acsi_rd, fdc_rd};
  assign sd_wr_req  = {acsi_wr, fdc_wr};
  assign sd_lba     = sel_acsi ? acsi_lba     : fdc_lba;
  assign sd_wr_byte = sel_acsi ? acsi_wr_byte : fdc_wr_byte;

  // the dma engine serializes floppy and acsi accesses
  a_no_dual_req: assert property (
    @(posedge clk_32) disable iff (!rst_n) !(fdc_req && acsi_req)
  );

endmodule

// File: src/st_input_merge.sv
`timescale 1ns/10ps
// reduces the hid keyboard matrix to the column byte the ikbd scans,
// and merges the mcu joystick with the board joystick pins
module st_input_merge import st_glue_pkg::*; (
  input  logic [kbd_rows-1:0][kbd_cols-1:0] kbd_rows_in, // per row, low = key down
  input  logic [kbd_rows-1:0]               kbd_row_sel, // active low row strobes
  input  logic [joy_w-1:0]                  hid_joy,     // from the mcu, active high
  input  logic [joy_w-1:0]                  joy_pins,    // board pins, active low
  output logic [kbd_cols-1:0]               kbd_col,
  output logic [joy_w-1:0]                  joy
);

  // wired and of all strobed rows, idle lines float high
  always_comb begin
    kbd_col = '1;
    for (int r = 0; r < kbd_rows; r++) begin
      if (!kbd_row_sel[r])
        kbd_col &= kbd_rows_in[r];
    end
  end

  // either source can press a direction
  assign joy = hid_joy | ~joy_pins;

endmodule

// File: src/st_glue_top.sv
`timescale 1ns/10ps
// glue between the board and the st chipset
// boot gating, ram scrambling, sd arbitration and input merging
module st_glue_top import st_glue_pkg::*; #(
  parameter logic [boot_cnt_w-1:0] timeout_cycles = boot_timeout_default
) (
  input  logic                              clk_32,
  input  logic                              rst_n,
  // board status and resets
  input  logic                              pll_lock,
  input  logic                              ram_ready,
  input  logic                              flash_ready,
  input  logic                              reset_button,
  input  logic                              sys_reset_req,
  input  logic                              coldboot,
  input  logic [sd_img_size_w-1:0]          sd_img_size,
  // chipset ram request
  input  logic [ram_addr_w:1]               ram_req_addr,
  input  logic                              ram_ras_n,
  // sector requesters
  input  logic [sd_chan_w-1:0]              fdc_rd,
  input  logic [sd_chan_w-1:0]              fdc_wr,
  input  logic [sd_lba_w-1:0]               fdc_lba,
  input  logic [sd_byte_w-1:0]              fdc_wr_byte,
  input  logic [sd_chan_w-1:0]              acsi_rd,
  input  logic [sd_chan_w-1:0]              acsi_wr,
  input  logic [sd_lba_w-1:0]               acsi_lba,
  input  logic [sd_byte_w-1:0]              acsi_wr_byte,
  // human input
  input  logic [kbd_rows-1:0][kbd_cols-1:0] kbd_rows_in,
  input  logic [kbd_rows-1:0]               kbd_row_sel,
  input  logic [joy_w-1:0]                  hid_joy,
  input  logic [joy_w-1:0]                  joy_pins,
  // outputs
  output logic                              core_reset_n,
  output logic                              sd_ready,
  output logic [ram_word_addr_w:1]          ram_addr_s,
  output logic                              ram_cs,
  output logic [sd_lba_w-1:0]               sd_lba,
  output logic [sd_byte_w-1:0]              sd_wr_byte,
  output logic [2*sd_chan_w-1:0]            sd_rd_req,
  output logic [2*sd_chan_w-1:0]            sd_wr_req,
  output logic [kbd_cols-1:0]               kbd_col,
  output logic [joy_w-1:0]                  joy
);

  // st reset gating
  boot_gate #(
    .timeout_cycles(timeout_cycles)
  ) boot_gate0 (
    .clk_32        (clk_32),
    .rst_n         (rst_n),
    .sd_img_size   (sd_img_size),
    .pll_lock      (pll_lock),
    .ram_ready     (ram_ready),
    .flash_ready   (flash_ready),
    .reset_button  (reset_button),
    .sys_reset_req (sys_reset_req),
    .sd_ready      (sd_ready),
    .core_reset_n  (core_reset_n)
  );

  ram_scrambler ram_scrambler0 (
    .clk_32       (clk_32),
    .rst_n        (rst_n),
    .coldboot     (coldboot),
    .ram_req_addr (ram_req_addr),
    .ram_ras_n    (ram_ras_n),
    .ram_addr_s   (ram_addr_s),
    .ram_cs       (ram_cs)
  );

  sd_arbiter sd_arbiter0 (
    .clk_32       (clk_32),
    .rst_n        (rst_n),
    .fdc_rd       (fdc_rd),
    .fdc_wr       (fdc_wr),
    .fdc_lba      (fdc_lba),
    .fdc_wr_byte  (fdc_wr_byte),
    .acsi_rd      (acsi_rd),
    .acsi_wr      (acsi_wr),
    .acsi_lba     (acsi_lba),
    .acsi_wr_byte (acsi_wr_byte),
    .sd_rd_req    (sd_rd_req),
    .sd_wr_req    (sd_wr_req),
    .sd_lba       (sd_lba),
    .sd_wr_byte   (sd_wr_byte)
  );

  st_input_merge st_input_merge0 (
    .kbd_rows_in (kbd_rows_in),
    .kbd_row_sel (kbd_row_sel),
    .hid_joy     (hid_joy),
    .joy_pins    (joy_pins),
    .kbd_col     (kbd_col),
    .joy         (joy)
  );

endmodule

// File: test/clk_gen.sv
`timescale 1ns/10ps
// clock and reset source for the st glue testbench
// 8 ns clock, reset low for 3 cycles at start and again on each restart pulse
module clk_gen (
  input  logic restart, // rising edge starts a new reset
  output logic clk_32,
  output logic rst_n
);

  initial begin
    clk_32 = 1'b0;
    forever #4 clk_32 = ~clk_32; // 125 MHz sim clock, period 8 ns
  end

  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (3) @(posedge clk_32);
      #1 rst_n = 1'b1; // release just after the edge
      @(posedge restart);
      rst_n = 1'b0;
    end
  end

endmodule

// File: test/tb_st_glue_top.sv
`timescale 1ns/10ps
// testbench for the st glue top level driven by steps from the golden file
// each step drives the dut 1 ns after a clock edge and samples 2 ns later
module tb_st_glue_top import st_glue_pkg::*; ();

  localparam int     clk_period_ns = 8;
  localparam int     step_cycles   = 400;  // watchdog budget per golden line
  localparam longint margin_ns     = 1000;

  logic                              restart;
  logic                              clk_32;
  logic                              rst_n;
  logic                              pll_lock;
  logic                              ram_ready;
  logic                              flash_ready;
  logic                              reset_button;
  logic                              sys_reset_req;
  logic                              coldboot;
  logic [sd_img_size_w-1:0]          sd_img_size;
  logic [ram_addr_w:1]               ram_req_addr;
  logic                              ram_ras_n;
  logic [sd_chan_w-1:0]              fdc_rd;
  logic [sd_chan_w-1:0]              fdc_wr;
  logic [sd_lba_w-1:0]               fdc_lba;
  logic [sd_byte_w-1:0]              fdc_wr_byte;
  logic [sd_chan_w-1:0]              acsi_rd;
  logic [sd_chan_w-1:0]              acsi_wr;
  logic [sd_lba_w-1:0]               acsi_lba;
  logic [sd_byte_w-1:0]              acsi_wr_byte;
  logic [kbd_rows-1:0][kbd_cols-1:0] kbd_rows_in;
  logic [kbd_rows-1:0]               kbd_row_sel;
  logic [joy_w-1:0]                  hid_joy;
  logic [joy_w-1:0]                  joy_pins;
  logic                              core_reset_n;
  logic                              sd_ready;
  logic [ram_word_addr_w:1]          ram_addr_s;
  logic                              ram_cs;
  logic [sd_lba_w-1:0]               sd_lba;
  logic [sd_byte_w-1:0]              sd_wr_byte;
  logic [2*sd_chan_w-1:0]            sd_rd_req;
  logic [2*sd_chan_w-1:0]            sd_wr_req;
  logic [kbd_cols-1:0]               kbd_col;
  logic [joy_w-1:0]                  joy;

  logic [6:0][31:0] vec_q[$]; // tag plus six fields per line
  int               seed;
  longint           wd_ns;
  logic             wd_armed = 1'b0;

  clk_gen clk_gen0 (.restart(restart), .clk_32(clk_32), .rst_n(rst_n));

  st_glue_top #(.timeout_cycles(32'd200)) dut0 (.*); // short boot wait

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic after_edge();
    @(posedge clk_32);
    #1;
  endtask

  task automatic idle_inputs();
    pll_lock      = 1'b1;
    ram_ready     = 1'b1;
    flash_ready   = 1'b1;
    reset_button  = 1'b0;
    sys_reset_req = 1'b0;
    coldboot      = 1'b0;
    sd_img_size   = '0;   // no image mounted
    ram_req_addr  = '0;
    ram_ras_n     = 1'b1;
    fdc_rd        = '0;
    fdc_wr        = '0;
    fdc_lba       = '0;
    fdc_wr_byte   = '0;
    acsi_rd       = '0;
    acsi_wr       = '0;
    acsi_lba      = '0;
    acsi_wr_byte  = '0;
    kbd_rows_in   = '1;   // no key down
    kbd_row_sel   = '1;
    hid_joy       = '0;
    joy_pins      = '1;
  endtask

  // new reset through the clock generator that returns right after release
  task automatic restart_dut();
    after_edge();
    idle_inputs();
    restart = 1'b1;
    wait (rst_n === 1'b0);
    wait (rst_n === 1'b1);
    restart = 1'b0;
  endtask

  task automatic boot_step(input logic [6:0][31:0] v);
    after_edge();
    sd_img_size                          = v[1];
    {pll_lock, ram_ready, flash_ready}   = v[2][2:0];
    reset_button                         = v[3][0];
    sys_reset_req                        = v[4][0];
    #2;
    compare_value("sd_ready", 32'(sd_ready), v[5]);
    compare_value("core_reset_n", 32'(core_reset_n), v[6]);
  endtask

  // counts edges from reset release until sd_ready up to the expected count
  task automatic timeout_count(input logic [6:0][31:0] v);
    int edges;
    edges       = 0;
    sd_img_size = '0;
    while (sd_ready !== 1'b1 && edges <= int'(v[1])) begin
      after_edge();
      edges++;
    end
    compare_value("edges from reset release to sd_ready", 32'(edges), v[1]);
  endtask

  task automatic pulse_coldboot(input int count);
    for (int i = 0; i < count; i++) begin
      after_edge();
      coldboot = 1'b1;
      after_edge();
      coldboot = 1'b0;
    end
  endtask

  task automatic scramble_check(input logic [6:0][31:0] v);
    pulse_coldboot(int'(v[1]));
    after_edge();
    ram_req_addr = v[2][ram_addr_w-1:0];
    ram_ras_n    = v[3][0];
    #2;
    compare_value("ram_addr_s", 32'(ram_addr_s), v[4]);
    compare_value("ram_cs", 32'(ram_cs), v[5]);
  endtask

  task automatic arbiter_step(input logic [6:0][31:0] v);
    logic [31:0]          rnd_f;
    logic [31:0]          rnd_a;
    logic [sd_byte_w-1:0] exp_byte;
    rnd_f = $random(seed); // write bytes are don't care in the file
    rnd_a = $random(seed);
    after_edge();
    fdc_rd       = v[1][7:6];
    fdc_wr       = v[1][5:4];
    acsi_rd      = v[1][3:2];
    acsi_wr      = v[1][1:0];
    fdc_lba      = v[2];
    acsi_lba     = v[3];
    fdc_wr_byte  = rnd_f[sd_byte_w-1:0];
    acsi_wr_byte = rnd_a[sd_byte_w-1:0];
    // byte follows the same side as the lba
    exp_byte = (v[4] == v[3]) ? rnd_a[sd_byte_w-1:0] : rnd_f[sd_byte_w-1:0];
    #2;
    compare_value("sd_lba", sd_lba, v[4]);
    compare_value("sd_wr_req and sd_rd_req", 32'({sd_wr_req, sd_rd_req}), v[5]);
    compare_value("sd_wr_byte", 32'(sd_wr_byte), 32'(exp_byte));
  endtask

  task automatic merge_check(input logic [6:0][31:0] v);
    logic [31:0] rnd;
    int          k;
    k = 0;
    after_edge();
    kbd_row_sel = v[1][kbd_rows-1:0];
    for (int r = 0; r < kbd_rows; r++) begin
      rnd = $random(seed);
      if (!v[1][r]) begin
        kbd_rows_in[r] = v[2][kbd_cols*(k%4) +: kbd_cols]; // bytes taken in turn
        k++;
      end else begin
        kbd_rows_in[r] = rnd[kbd_cols-1:0]; // noise on rows not strobed
      end
    end
    hid_joy  = v[3][joy_w-1:0];
    joy_pins = v[4][joy_w-1:0];
    #2;
    compare_value("kbd_col", 32'(kbd_col), v[5]);
    compare_value("joy", 32'(joy), v[6]);
  endtask

  initial begin
    int               fd;
    int               code;
    int               got;
    string            line;
    logic [6:0][31:0] v;
    seed    = 68066;
    restart = 1'b0;
    idle_inputs();
    fd = $fopen("test/st_glue_golden.txt", "r");
    if (fd == 0)
      abort_run("could not open the golden file");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        got = $sscanf(line, "%h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
        if (got != 7)
          abort_run("a golden line does not hold seven fields");
        vec_q.push_back(v);
      end
    end
    $fclose(fd);
    if (vec_q.size() == 0)
      abort_run("the golden file holds no steps");
    wd_ns    = longint'(vec_q.size()) * step_cycles * clk_period_ns + margin_ns;
    wd_armed = 1'b1;

    wait (rst_n === 1'b1); // first reset from clk_gen
    foreach (vec_q[i]) begin
      v = vec_q[i];
      case (v[0])
        32'h0: restart_dut();
        32'h1: boot_step(v);
        32'h2: timeout_count(v);
        32'h3: scramble_check(v);
        32'h4: arbiter_step(v);
        32'h5: merge_check(v);
        default: abort_run("unknown behavior tag in the golden file");
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

  // watchdog sized from the number of golden lines
  initial begin
    wait (wd_armed);
    #(wd_ns);
    abort_run("timeout, the golden steps did not finish in time");
  end

endmodule

// File: st_glue_top.f
src/st_glue_pkg.sv
src/boot_gate.sv
src/ram_scrambler.sv
src/sd_arbiter.sv
src/st_input_merge.sv
src/st_glue_top.sv
test/clk_gen.sv
test/tb_st_glue_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the st glue testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_st_glue_top \
  -f st_glue_top.f \
  -o sim_st_glue \
  && ./obj_dir/sim_st_glue 2>&1 | tee sim.log \
  || echo "build or run stopped early"

grep -q "TESTS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: test/st_glue_golden.txt
# tag f1 f2 f3 f4 f5 f6, all hex, one step per line
# 0 restart | 1 img ready{pll,ram,flash} button sysreq exp_sd_ready exp_core_reset_n
# 2 exp_edges_to_sd_ready | 3 coldboot_pulses addr ras_n exp_addr_s exp_cs
# 4 req{fdc_rd,fdc_wr,acsi_rd,acsi_wr} fdc_lba acsi_lba exp_lba exp{wr_req,rd_req}
# 5 row_sel row_bytes hid_joy joy_pins exp_kbd_col exp_joy
0 0 0 0 0 0 0
1 0 7 0 0 0 0
1 1000 7 0 0 0 0
1 1000 7 0 0 1 1
1 1000 7 1 0 1 0
1 1000 7 0 1 1 0
1 1000 3 0 0 1 0
1 0 7 0 0 1 1
0 0 0 0 0 0 0
2 c9 0 0 0 0 0
3 0 012345 0 012345 1 0
3 1 012345 0 012341 1 0
3 1 00abc0 0 00abc8 1 0
3 1 3ffffc 0 3ffff0 1 0
3 0 412345 0 012349 0 0
3 1 0000ff 0 0000ff 1 0
3 0 0000ff 1 0000ff 0 0
3 2 155550 0 155558 1 0
4 00 100 2000 100 00 0
4 04 100 2000 2000 04 0
4 00 100 2000 2000 00 0
4 00 111 2222 2222 00 0
4 40 111 2222 2222 01 0
4 40 111 2222 111 01 0
4 00 111 2222 111 00 0
4 02 111 2222 2222 80 0
4 20 111 2222 2222 20 0
4 20 111 2222 111 20 0
4 09 333 4444 4444 48 0
4 00 333 4444 4444 00 0
4 80 333 4444 4444 02 0
4 80 333 4444 333 02 0
5 7fff 00000000 00 1f ff 00
5 7ffe 000000a5 01 1f a5 01
5 7ffc 00003cf0 00 1e 30 01
5 3fff 0000007e 10 0f 7e 10
5 5ff5 00eedbf7 0a 15 c2 0a
5 0000 7fbfdfef 1f 1f 0f 1f
5 7f7f 00000055 00 00 55 1f
